/* exec_stage.f */
+incdir+verif
logic/exec_isa_pkg.sv
logic/exec_state_pkg.sv
logic/exec_ifs.sv
logic/exec_alu.sv
logic/branch_eval.sv
logic/control_regs.sv
logic/exec_result_latch.sv
logic/exec_stage.sv
verif/exec_stage_tb.sv

/* logic/branch_eval.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_eval (
	input  wire exec_isa_pkg::branch_cc_e i_cond,
	flags_if.dst                          i_flags,
	output logic                          o_met
);

	logic signed_lt;

	assign signed_lt = i_flags.n != i_flags.o;

	// Unsigned tests use c and z, signed tests use n, o and z
	always_comb begin
		case (i_cond)
		exec_isa_pkg::NE:   o_met = !i_flags.z;
		exec_isa_pkg::EQ:   o_met = i_flags.z;
		exec_isa_pkg::GT:   o_met = i_flags.c && !i_flags.z;
		exec_isa_pkg::LT:   o_met = !i_flags.c;
		exec_isa_pkg::GTS:  o_met = !i_flags.z && !signed_lt;
		exec_isa_pkg::LTS:  o_met = signed_lt;
		exec_isa_pkg::B:    o_met = 1'b1;
		exec_isa_pkg::GTE:  o_met = i_flags.c;
		exec_isa_pkg::GTES: o_met = !signed_lt;
		exec_isa_pkg::LTE:  o_met = !i_flags.c || i_flags.z;
		exec_isa_pkg::LTES: o_met = signed_lt || i_flags.z;
		default:            o_met = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/control_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module control_regs (
	input  wire logic                        clk,
	input  wire logic                        rst,
	alu_result_if.dst                        i_res,
	input  wire logic                        i_update_flags,
	input  wire logic                        i_update_carry,
	input  wire exec_state_pkg::cr_sel_e     i_cr_sel,
	input  wire logic                        i_write_cr,
	input  wire exec_isa_pkg::word_t         i_ra,
	input  wire exec_isa_pkg::word_t         i_pc_plus_4,
	input  wire exec_isa_pkg::word_t         i_mar,
	input  wire logic                        i_is_swi,
	input  wire logic                        i_is_rfe,
	input  wire logic                        i_exception_start,
	input  wire logic                        i_exception_disable_irqs,
	input  wire logic                        i_irq_start,
	input  wire logic                        i_data_abort,
	input  wire exec_isa_pkg::word_t         i_irq_fault_address,
	input  wire exec_state_pkg::cr_sel_e     i_dbg_cr_sel,
	input  wire exec_isa_pkg::word_t         i_dbg_cr_wr_val,
	input  wire logic                        i_dbg_cr_wr_en,
	flags_if.src                             o_flags,
	output logic                             o_irqs_enabled,
	output exec_state_pkg::vector_base_t     o_vector_base,
	output exec_isa_pkg::word_t              o_fault_addr,
	output exec_isa_pkg::word_t              o_cr_read,
	output exec_isa_pkg::word_t              o_dbg_cr_val
);

	exec_state_pkg::vector_base_t vector_base;
	exec_state_pkg::psr_t psr;
	exec_state_pkg::psr_t psr_next;
	exec_state_pkg::psr_t saved_psr;
	exec_isa_pkg::word_t fault_addr;
	exec_isa_pkg::word_t data_fault_addr;
	exec_isa_pkg::word_t cr_view [8];
	logic [4:0] dbg_wr;
	logic [4:0] ins_wr;
	logic any_exception;

	always_comb begin
		for (int i = 0; i < 5; i++) begin
			dbg_wr[i] = i_dbg_cr_wr_en && (i_dbg_cr_sel == i);
			ins_wr[i] = i_write_cr && (i_cr_sel == i);
		end
	end

	assign any_exception = i_is_swi || i_exception_start || i_exception_disable_irqs ||
		i_irq_start || i_data_abort;

	// --------------------------------------------------
	// Later writes to the PSR take priority
	// --------------------------------------------------
	always_comb begin
		psr_next = psr;
		if (i_update_flags) begin
			psr_next[exec_state_pkg::PSR_Z] = i_res.z;
			psr_next[exec_state_pkg::PSR_N] = i_res.n;
			psr_next[exec_state_pkg::PSR_O] = i_res.o;
		end
		if (i_update_carry)
			psr_next[exec_state_pkg::PSR_C] = i_res.c;
		if (i_exception_disable_irqs)
			psr_next[exec_state_pkg::PSR_IRQ] = 1'b0;
		if (i_is_rfe)
			psr_next = saved_psr;
		if (dbg_wr[exec_state_pkg::PSR])
			psr_next = i_dbg_cr_wr_val[4:0];
		if (ins_wr[exec_state_pkg::PSR])
			psr_next = i_ra[4:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			psr <= '0;
		else
			psr <= psr_next;
	end

	always_ff @(posedge clk) begin
		if (rst)
			vector_base <= '0;
		else if (dbg_wr[exec_state_pkg::VECTOR])
			vector_base <= i_dbg_cr_wr_val[31:6];
		else if (ins_wr[exec_state_pkg::VECTOR])
			vector_base <= i_ra[31:6];
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= '0;
		else if (dbg_wr[exec_state_pkg::SAVED_PSR])
			saved_psr <= i_dbg_cr_wr_val[4:0];
		else if (any_exception)
			saved_psr <= psr; // State to restore on RFE
		else if (ins_wr[exec_state_pkg::SAVED_PSR])
			saved_psr <= i_ra[4:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_addr <= '0;
		else if (dbg_wr[exec_state_pkg::FAULT])
			fault_addr <= i_dbg_cr_wr_val;
		else if (i_irq_start)
			fault_addr <= i_irq_fault_address;
		else if (i_exception_disable_irqs)
			fault_addr <= i_pc_plus_4;
		else if (ins_wr[exec_state_pkg::FAULT])
			fault_addr <= i_ra;
	end

	always_ff @(posedge clk) begin
		if (rst)
			data_fault_addr <= '0;
		else if (dbg_wr[exec_state_pkg::DATA_FAULT])
			data_fault_addr <= i_dbg_cr_wr_val;
		else if (i_data_abort)
			data_fault_addr <= i_mar; // Address of the access that faulted
		else if (ins_wr[exec_state_pkg::DATA_FAULT])
			data_fault_addr <= i_ra;
	end

	// --------------------------------------------------
	// Read ports
	// --------------------------------------------------
	always_comb begin
		cr_view[exec_state_pkg::VECTOR] = {vector_base, 6'b0};
		cr_view[exec_state_pkg::PSR] = {27'b0, psr};
		cr_view[exec_state_pkg::SAVED_PSR] = {27'b0, saved_psr};
		cr_view[exec_state_pkg::FAULT] = fault_addr;
		cr_view[exec_state_pkg::DATA_FAULT] = data_fault_addr;
		for (int i = 5; i < 8; i++)
			cr_view[i] = '0;
	end

	assign o_cr_read = cr_view[i_cr_sel];
	assign o_dbg_cr_val = cr_view[i_dbg_cr_sel];

	assign o_flags.z = psr[exec_state_pkg::PSR_Z];
	assign o_flags.c = psr[exec_state_pkg::PSR_C];
	assign o_flags.n = psr[exec_state_pkg::PSR_N];
	assign o_flags.o = psr[exec_state_pkg::PSR_O];
	assign o_irqs_enabled = psr[exec_state_pkg::PSR_IRQ];
	assign o_vector_base = vector_base;
	assign o_fault_addr = fault_addr;

endmodule

`default_nettype wire

/* logic/exec_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_alu (
	input  wire exec_isa_pkg::word_t         i_ra,
	input  wire exec_isa_pkg::word_t         i_rb,
	input  wire exec_isa_pkg::word_t         i_imm32,
	input  wire exec_isa_pkg::word_t         i_pc_plus_4,
	input  wire exec_isa_pkg::alu_opc_e      i_alu_opc,
	input  wire logic                        i_op1_ra,
	input  wire logic                        i_op1_rb,
	input  wire logic                        i_op2_rb,
	input  wire logic                        i_carry_in,
	input  wire exec_isa_pkg::word_t         i_cr_read,
	input  wire exec_state_pkg::vector_base_t i_vector_base,
	input  wire exec_isa_pkg::word_t         i_fault_addr,
	output exec_isa_pkg::word_t              o_op2,
	alu_result_if.src                        o_res
);

	exec_isa_pkg::word_t op1;
	exec_isa_pkg::word_t op2;
	exec_isa_pkg::word_t q;
	logic carry;
	logic ovf;
	logic neg;

	assign op1 = i_op1_ra ? i_ra : (i_op1_rb ? i_rb : i_pc_plus_4);
	assign op2 = i_op2_rb ? i_rb : i_imm32;

	// --------------------------------------------------
	// Result and carry per opcode
	// --------------------------------------------------
	always_comb begin
		carry = 1'b0;
		ovf = 1'b0;
		neg = 1'b0;
		q = '0;
		case (i_alu_opc)
		exec_isa_pkg::ADD:   {carry, q} = op1 + op2;
		exec_isa_pkg::ADDC:  {carry, q} = op1 + op2 + {31'b0, i_carry_in};
		exec_isa_pkg::SUB:   {carry, q} = op1 - op2; // Carry holds the borrow
		exec_isa_pkg::SUBC:  {carry, q} = op1 - op2 - {31'b0, i_carry_in};
		exec_isa_pkg::MUL:   {carry, q} = op1 * op2;
		exec_isa_pkg::LSL:   {carry, q} = {1'b0, op1} << op2[4:0];
		exec_isa_pkg::LSR:   q = op1 >> op2[4:0];
		exec_isa_pkg::AND:   q = op1 & op2;
		exec_isa_pkg::XOR:   q = op1 ^ op2;
		exec_isa_pkg::BIC:   q = op1 & ~(32'b1 << op2[4:0]);
		exec_isa_pkg::BST:   q = op1 | (32'b1 << op2[4:0]);
		exec_isa_pkg::OR:    q = op1 | op2;
		exec_isa_pkg::COPYB: q = op2;
		exec_isa_pkg::CMP: begin
			{carry, q} = op1 - op2;
			carry = ~carry; // Set when op1 >= op2 unsigned
			ovf = (op1[31] ^ op2[31]) && (q[31] == op2[31]);
			neg = q[31];
		end
		exec_isa_pkg::MOVHI: q = op1 | {16'b0, op2[15:0]};
		exec_isa_pkg::ASR:   q = $signed(op1) >>> op2[4:0];
		exec_isa_pkg::COPYA: q = op1;
		exec_isa_pkg::GCR:   q = i_cr_read;
		exec_isa_pkg::SWI:   q = {i_vector_base, 6'h08}; // Software interrupt vector
		exec_isa_pkg::RFE:   q = i_fault_addr;
		default:             q = '0;
		endcase
	end

	assign o_op2 = op2;
	assign o_res.q = q;
	assign o_res.c = carry;
	assign o_res.z = (op1 == op2);
	assign o_res.n = neg;
	assign o_res.o = ovf;

endmodule

`default_nettype wire

/* logic/exec_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

// ALU result together with the flags it produced
interface alu_result_if;
	exec_isa_pkg::word_t q;
	logic c;
	logic z;
	logic n;
	logic o;

	modport src (output q, c, z, n, o);
	modport dst (input q, c, z, n, o);
endinterface

// Current state of the condition flags
interface flags_if;
	logic z;
	logic c;
	logic n;
	logic o;

	modport src (output z, c, n, o);
	modport dst (input z, c, n, o);
endinterface

`default_nettype wire

/* logic/exec_isa_pkg.sv */
`default_nettype none

package exec_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_sel_t;
	typedef logic [1:0] mem_width_t;

	// --------------------------------------------------
	// ALU operations
	// --------------------------------------------------
	typedef enum logic [4:0] {
		ADD   = 5'd0,
		ADDC  = 5'd1,
		SUB   = 5'd2,
		SUBC  = 5'd3,
		MUL   = 5'd4,
		LSL   = 5'd5,
		LSR   = 5'd6,
		AND   = 5'd7,
		XOR   = 5'd8,
		BIC   = 5'd9,
		BST   = 5'd10,
		OR    = 5'd11,
		COPYB = 5'd12,
		CMP   = 5'd13,
		MOVHI = 5'd14,
		ASR   = 5'd15,
		COPYA = 5'd16,
		GCR   = 5'd17,
		SWI   = 5'd18,
		RFE   = 5'd19
	} alu_opc_e;

	// Code 0 is unused, so a zeroed field never branches
	typedef enum logic [3:0] {
		NE   = 4'd1,
		EQ   = 4'd2,
		GT   = 4'd3,
		LT   = 4'd4,
		GTS  = 4'd5,
		LTS  = 4'd6,
		B    = 4'd7,
		GTE  = 4'd8,
		GTES = 4'd9,
		LTE  = 4'd10,
		LTES = 4'd11
	} branch_cc_e;

	typedef enum logic [1:0] {
		ARITH  = 2'd0,
		BRANCH = 2'd1,
		LDSTR  = 2'd2,
		MISC   = 2'd3
	} instr_class_e;

endpackage

`default_nettype wire

/* logic/exec_result_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_result_latch (
	input  wire logic                       clk,
	input  wire logic                       rst,
	alu_result_if.dst                       i_res,
	input  wire exec_isa_pkg::word_t        i_op2,
	input  wire exec_isa_pkg::word_t        i_rb,
	input  wire exec_isa_pkg::word_t        i_pc_plus_4,
	input  wire exec_isa_pkg::reg_sel_t     i_rd_sel,
	input  wire logic                       i_update_rd,
	input  wire logic                       i_mem_load,
	input  wire logic                       i_mem_store,
	input  wire exec_isa_pkg::mem_width_t   i_mem_width,
	input  wire logic                       i_is_call,
	input  wire logic                       i_valid,
	input  wire logic                       i_branch_met,
	input  wire logic                       i_is_swi,
	input  wire logic                       i_is_rfe,
	input  wire exec_isa_pkg::instr_class_e i_class,
	output exec_isa_pkg::word_t             o_alu_out,
	output exec_isa_pkg::word_t             o_wr_val,
	output exec_isa_pkg::word_t             o_mar,
	output exec_isa_pkg::word_t             o_mdr,
	output exec_isa_pkg::reg_sel_t          o_rd_sel,
	output logic                            o_wr_result,
	output logic                            o_mem_load,
	output logic                            o_mem_store,
	output logic                            o_mem_wr_en,
	output exec_isa_pkg::mem_width_t        o_mem_width,
	output logic                            o_valid,
	output logic                            o_branch_taken,
	output logic                            o_stall_clear
);

	logic is_branch;

	assign is_branch = (i_class == exec_isa_pkg::BRANCH);

	always_ff @(posedge clk) begin
		if (rst) begin
			o_wr_result <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
			o_mem_wr_en <= 1'b0;
			o_valid <= 1'b0;
			o_branch_taken <= 1'b0;
			o_stall_clear <= 1'b0;
		end else begin
			o_wr_result <= i_update_rd;
			o_mem_load <= i_mem_load;
			o_mem_store <= i_mem_store;
			o_mem_wr_en <= i_mem_store;
			o_valid <= i_valid;
			o_branch_taken <= (is_branch && i_branch_met) || i_is_swi || i_is_rfe;
			o_stall_clear <= is_branch; // Fetch may resume once the branch resolves
		end
	end

	always_ff @(posedge clk) begin
		o_alu_out <= i_res.q;
		o_rd_sel <= i_rd_sel;
		o_wr_val <= i_is_call ? i_pc_plus_4 : (i_mem_store ? i_op2 : i_res.q);
		if (i_mem_load || i_mem_store) begin // Held across other instructions
			o_mar <= i_res.q;
			o_mem_width <= i_mem_width;
			if (i_mem_store)
				o_mdr <= i_rb;
		end
	end

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire exec_isa_pkg::word_t         i_ra,
	input  wire exec_isa_pkg::word_t         i_rb,
	input  wire exec_isa_pkg::word_t         i_imm32,
	input  wire exec_isa_pkg::word_t         i_pc_plus_4,
	input  wire exec_isa_pkg::reg_sel_t      i_rd_sel,
	input  wire logic                        i_update_rd,
	input  wire exec_isa_pkg::alu_opc_e      i_alu_opc,
	input  wire logic                        i_op1_ra,
	input  wire logic                        i_op1_rb,
	input  wire logic                        i_op2_rb,
	input  wire logic                        i_mem_load,
	input  wire logic                        i_mem_store,
	input  wire exec_isa_pkg::mem_width_t    i_mem_width,
	input  wire exec_isa_pkg::branch_cc_e    i_branch_cond,
	input  wire exec_isa_pkg::instr_class_e  i_class,
	input  wire logic                        i_is_call,
	input  wire logic                        i_update_carry,
	input  wire logic                        i_update_flags,
	input  wire exec_state_pkg::cr_sel_e     i_cr_sel,
	input  wire logic                        i_write_cr,
	input  wire logic                        i_is_swi,
	input  wire logic                        i_is_rfe,
	input  wire logic                        i_data_abort,
	input  wire logic                        i_exception_start,
	input  wire logic                        i_exception_disable_irqs,
	input  wire logic                        i_irq_start,
	input  wire exec_isa_pkg::word_t         i_irq_fault_address,
	input  wire logic                        i_valid,
	input  wire exec_state_pkg::cr_sel_e     i_dbg_cr_sel,
	input  wire exec_isa_pkg::word_t         i_dbg_cr_wr_val,
	input  wire logic                        i_dbg_cr_wr_en,
	output exec_isa_pkg::word_t              o_alu_out,
	output exec_isa_pkg::word_t              o_wr_val,
	output logic                             o_wr_result,
	output exec_isa_pkg::reg_sel_t           o_rd_sel,
	output logic                             o_branch_taken,
	output logic                             o_stall_clear,
	output logic                             o_mem_load,
	output logic                             o_mem_store,
	output logic                             o_mem_wr_en,
	output exec_isa_pkg::mem_width_t         o_mem_width,
	output exec_isa_pkg::word_t              o_mar,
	output exec_isa_pkg::word_t              o_mdr,
	output logic                             o_valid,
	output logic                             o_irqs_enabled,
	output exec_state_pkg::vector_base_t     o_vector_base,
	output exec_isa_pkg::word_t              o_dbg_cr_val
);

	exec_isa_pkg::word_t op2;
	exec_isa_pkg::word_t cr_read;
	exec_isa_pkg::word_t fault_addr;
	logic branch_met;

	alu_result_if alu_res ();
	flags_if flags ();

	exec_alu alu0 (
		.i_ra(i_ra), .i_rb(i_rb), .i_imm32(i_imm32), .i_pc_plus_4(i_pc_plus_4),
		.i_alu_opc(i_alu_opc), .i_op1_ra(i_op1_ra), .i_op1_rb(i_op1_rb),
		.i_op2_rb(i_op2_rb), .i_carry_in(flags.c), .i_cr_read(cr_read),
		.i_vector_base(o_vector_base), .i_fault_addr(fault_addr),
		.o_op2(op2), .o_res(alu_res.src)
	);

	branch_eval branch0 (.i_cond(i_branch_cond), .i_flags(flags.dst), .o_met(branch_met));

	control_regs cr0 (
		.clk(clk), .rst(rst), .i_res(alu_res.dst),
		.i_update_flags(i_update_flags), .i_update_carry(i_update_carry),
		.i_cr_sel(i_cr_sel), .i_write_cr(i_write_cr), .i_ra(i_ra),
		.i_pc_plus_4(i_pc_plus_4), .i_mar(o_mar), .i_is_swi(i_is_swi),
		.i_is_rfe(i_is_rfe), .i_exception_start(i_exception_start),
		.i_exception_disable_irqs(i_exception_disable_irqs),
		.i_irq_start(i_irq_start), .i_data_abort(i_data_abort),
		.i_irq_fault_address(i_irq_fault_address), .i_dbg_cr_sel(i_dbg_cr_sel),
		.i_dbg_cr_wr_val(i_dbg_cr_wr_val), .i_dbg_cr_wr_en(i_dbg_cr_wr_en),
		.o_flags(flags.src), .o_irqs_enabled(o_irqs_enabled),
		.o_vector_base(o_vector_base), .o_fault_addr(fault_addr),
		.o_cr_read(cr_read), .o_dbg_cr_val(o_dbg_cr_val)
	);

	exec_result_latch latch0 (
		.clk(clk), .rst(rst), .i_res(alu_res.dst), .i_op2(op2), .i_rb(i_rb),
		.i_pc_plus_4(i_pc_plus_4), .i_rd_sel(i_rd_sel), .i_update_rd(i_update_rd),
		.i_mem_load(i_mem_load), .i_mem_store(i_mem_store), .i_mem_width(i_mem_width),
		.i_is_call(i_is_call), .i_valid(i_valid), .i_branch_met(branch_met),
		.i_is_swi(i_is_swi), .i_is_rfe(i_is_rfe), .i_class(i_class),
		.o_alu_out(o_alu_out), .o_wr_val(o_wr_val), .o_mar(o_mar), .o_mdr(o_mdr),
		.o_rd_sel(o_rd_sel), .o_wr_result(o_wr_result), .o_mem_load(o_mem_load),
		.o_mem_store(o_mem_store), .o_mem_wr_en(o_mem_wr_en),
		.o_mem_width(o_mem_width), .o_valid(o_valid),
		.o_branch_taken(o_branch_taken), .o_stall_clear(o_stall_clear)
	);

endmodule

`default_nettype wire

/* logic/exec_state_pkg.sv */
`default_nettype none

package exec_state_pkg;

	typedef enum logic [2:0] {
		VECTOR     = 3'd0,
		PSR        = 3'd1,
		SAVED_PSR  = 3'd2,
		FAULT      = 3'd3,
		DATA_FAULT = 3'd4
	} cr_sel_e;

	typedef logic [4:0] psr_t; // {irqs_enabled, n, o, c, z}
	typedef logic [25:0] vector_base_t; // Address bits 31:6

	// Bit positions inside psr_t
	parameter int PSR_Z = 0;
	parameter int PSR_C = 1;
	parameter int PSR_O = 2;
	parameter int PSR_N = 3;
	parameter int PSR_IRQ = 4;

endpackage

`default_nettype wire

/* verif/exec_stage_tests.svh */
task automatic reset_values();
	exec_isa_pkg::word_t val;
	start_test("reset_values");
	check_val("status bits", 0, {o_branch_taken, o_wr_result, o_mem_load, o_mem_store,
		o_mem_wr_en, o_valid, o_stall_clear, o_irqs_enabled});
	for (int i = 0; i < 8; i++) begin
		read_cr(exec_state_pkg::cr_sel_e'(i), val);
		check_val($sformatf("cr %0d", i), 0, val);
	end
	finish_test();
endtask

task automatic alu_random_ops();
	exec_isa_pkg::word_t a;
	exec_isa_pkg::word_t b;
	exec_isa_pkg::word_t exp;
	exec_isa_pkg::alu_opc_e opc;
	start_test("alu_random_ops");
	for (int p = 0; p < ALU_PAIRS; p++) begin
		a = $urandom();
		b = $urandom();
		for (int k = 0; k < ALU_OP_COUNT; k++) begin
			opc = alu_op_at(k);
			clear_inputs();
			i_alu_opc = opc;
			i_ra = a;
			i_rb = b;
			i_update_rd = 1'b1;
			i_valid = 1'b1;
			next_edge();
			exp = alu_ref(opc, a, b);
			check_val(opc.name(), exp, o_alu_out);
			check_val("wr_val", exp, o_wr_val);
			check_val("wr_result and valid", 2'b11, {o_wr_result, o_valid});
		end
	end
	finish_test();
endtask

task automatic carry_chain();
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] exp;
	exec_isa_pkg::word_t lo;
	start_test("carry_chain");
	a = {$urandom(), $urandom() | 32'h8000_0000}; // Low halves always carry
	b = {$urandom(), $urandom() | 32'h8000_0000};
	clear_inputs();
	i_alu_opc = exec_isa_pkg::ADD;
	i_ra = a[31:0];
	i_rb = b[31:0];
	i_update_carry = 1'b1;
	next_edge();
	lo = o_alu_out;
	clear_inputs();
	i_alu_opc = exec_isa_pkg::ADDC;
	i_ra = a[63:32];
	i_rb = b[63:32];
	next_edge();
	exp = a + b;
	check_val("add low", exp[31:0], lo);
	check_val("add high", exp[63:32], o_alu_out);
	a[31:0] = $urandom() & 32'h0fff_ffff; // Low halves always borrow
	b[31:0] = $urandom() | 32'hf000_0000;
	clear_inputs();
	i_alu_opc = exec_isa_pkg::SUB;
	i_ra = a[31:0];
	i_rb = b[31:0];
	i_update_carry = 1'b1;
	next_edge();
	lo = o_alu_out;
	clear_inputs();
	i_alu_opc = exec_isa_pkg::SUBC;
	i_ra = a[63:32];
	i_rb = b[63:32];
	next_edge();
	exp = a - b;
	check_val("sub low", exp[31:0], lo);
	check_val("sub high", exp[63:32], o_alu_out);
	finish_test();
endtask

task automatic compare_and_branch();
	exec_isa_pkg::word_t a;
	exec_isa_pkg::word_t b;
	exec_isa_pkg::branch_cc_e cc;
	start_test("compare_and_branch");
	for (int p = 0; p < CMP_PAIRS; p++) begin
		a = $urandom();
		case (p)
		0: b = a;
		2: begin
			a[31] = 1'b0; // Positive minus negative with equal low bits overflows
			b = a ^ 32'h8000_0000;
		end
		default: b = $urandom();
		endcase
		clear_inputs();
		i_alu_opc = exec_isa_pkg::CMP;
		i_ra = a;
		i_rb = b;
		i_update_flags = 1'b1;
		i_update_carry = 1'b1;
		next_edge();
		check_val("cmp taken and stall_clear", 0, {o_branch_taken, o_stall_clear});
		for (int k = 1; k <= CONDITIONS; k++) begin
			cc = exec_isa_pkg::branch_cc_e'(k);
			clear_inputs();
			i_class = exec_isa_pkg::BRANCH;
			i_branch_cond = cc;
			next_edge();
			check_val({cc.name(), " taken"}, cond_ref(cc, a, b), o_branch_taken);
			check_val("stall_clear", 1, o_stall_clear);
		end
	end
	finish_test();
endtask

task automatic control_reg_access();
	exec_isa_pkg::word_t v1;
	exec_isa_pkg::word_t v2;
	exec_isa_pkg::word_t v3;
	exec_isa_pkg::word_t val;
	start_test("control_reg_access");
	v1 = $urandom();
	v2 = $urandom();
	v3 = $urandom();
	clear_inputs();
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::VECTOR;
	i_ra = v1;
	next_edge();
	read_cr(exec_state_pkg::VECTOR, val);
	check_val("vector via debug", {v1[31:6], 6'b0}, val);
	check_val("vector base port", v1[31:6], o_vector_base);
	clear_inputs();
	i_alu_opc = exec_isa_pkg::GCR;
	i_cr_sel = exec_state_pkg::VECTOR;
	next_edge();
	check_val("vector via gcr", {v1[31:6], 6'b0}, o_alu_out);
	clear_inputs();
	i_dbg_cr_wr_en = 1'b1;
	i_dbg_cr_sel = exec_state_pkg::FAULT;
	i_dbg_cr_wr_val = v2;
	next_edge();
	read_cr(exec_state_pkg::FAULT, val);
	check_val("fault via debug", v2, val);
	// Both ports write the fault register in one cycle
	clear_inputs();
	i_dbg_cr_wr_en = 1'b1;
	i_dbg_cr_sel = exec_state_pkg::FAULT;
	i_dbg_cr_wr_val = v3;
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::FAULT;
	i_ra = v1;
	next_edge();
	read_cr(exec_state_pkg::FAULT, val);
	check_val("fault debug priority", v3, val);
	clear_inputs();
	i_alu_opc = exec_isa_pkg::GCR;
	i_cr_sel = exec_state_pkg::FAULT;
	next_edge();
	check_val("fault via gcr", v3, o_alu_out);
	clear_inputs();
	i_dbg_cr_wr_en = 1'b1;
	i_dbg_cr_sel = exec_state_pkg::PSR;
	i_dbg_cr_wr_val = ~v3;
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::PSR;
	i_ra = v3;
	next_edge();
	read_cr(exec_state_pkg::PSR, val);
	check_val("psr instruction priority", {27'b0, v3[4:0]}, val);
	clear_inputs();
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::SAVED_PSR;
	i_ra = ~v3;
	i_exception_start = 1'b1;
	next_edge();
	read_cr(exec_state_pkg::SAVED_PSR, val);
	check_val("saved psr capture", {27'b0, v3[4:0]}, val);
	clear_inputs();
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::cr_sel_e'(3'd5);
	i_ra = v1;
	i_dbg_cr_wr_en = 1'b1;
	i_dbg_cr_sel = exec_state_pkg::cr_sel_e'(3'd6);
	i_dbg_cr_wr_val = v2;
	next_edge();
	for (int i = 5; i < 8; i++) begin
		read_cr(exec_state_pkg::cr_sel_e'(i), val);
		check_val($sformatf("unused cr %0d", i), 0, val);
	end
	clear_inputs();
	i_alu_opc = exec_isa_pkg::GCR;
	i_cr_sel = exec_state_pkg::cr_sel_e'(3'd5);
	next_edge();
	check_val("unused cr via gcr", 0, o_alu_out);
	finish_test();
endtask

task automatic exception_entry_exit();
	exec_isa_pkg::word_t vec;
	exec_isa_pkg::word_t ret;
	exec_isa_pkg::word_t irq_addr;
	exec_isa_pkg::word_t val;
	exec_state_pkg::psr_t psr_val;
	start_test("exception_entry_exit");
	vec = $urandom();
	ret = $urandom();
	irq_addr = $urandom();
	psr_val = 5'b10101; // Interrupts on with o and z set
	clear_inputs();
	i_write_cr = 1'b1;
	i_cr_sel = exec_state_pkg::VECTOR;
	i_ra = vec;
	i_dbg_cr_wr_en = 1'b1;
	i_dbg_cr_sel = exec_state_pkg::PSR;
	i_dbg_cr_wr_val = {27'b0, psr_val};
	next_edge();
	check_val("irqs enabled", 1, o_irqs_enabled);
	clear_inputs();
	i_alu_opc = exec_isa_pkg::SWI;
	i_is_swi = 1'b1;
	next_edge();
	check_val("swi vector", {vec[31:6], 6'h08}, o_alu_out);
	check_val("swi taken", 1, o_branch_taken);
	read_cr(exec_state_pkg::SAVED_PSR, val);
	check_val("swi saved psr", psr_val, val);
	clear_inputs();
	i_irq_start = 1'b1;
	i_irq_fault_address = irq_addr;
	next_edge();
	read_cr(exec_state_pkg::FAULT, val);
	check_val("irq fault address", irq_addr, val);
	clear_inputs();
	i_exception_disable_irqs = 1'b1;
	i_pc_plus_4 = ret;
	next_edge();
	check_val("irqs disabled", 0, o_irqs_enabled);
	read_cr(exec_state_pkg::FAULT, val);
	check_val("return address", ret, val);
	clear_inputs();
	i_alu_opc = exec_isa_pkg::RFE;
	i_is_rfe = 1'b1;
	next_edge();
	check_val("rfe address", ret, o_alu_out);
	check_val("rfe taken", 1, o_branch_taken);
	read_cr(exec_state_pkg::PSR, val);
	check_val("rfe psr", psr_val, val);
	clear_inputs();
	i_irq_start = 1'b1; // Outranks the disable strobe on the fault register
	i_irq_fault_address = irq_addr ^ 32'h0000_ffff;
	i_exception_disable_irqs = 1'b1;
	i_pc_plus_4 = ret;
	next_edge();
	read_cr(exec_state_pkg::FAULT, val);
	check_val("fault priority", irq_addr ^ 32'h0000_ffff, val);
	finish_test();
endtask

task automatic memory_and_call();
	exec_isa_pkg::word_t base;
	exec_isa_pkg::word_t offs;
	exec_isa_pkg::word_t data;
	exec_isa_pkg::word_t addr;
	exec_isa_pkg::word_t val;
	start_test("memory_and_call");
	base = $urandom();
	offs = $urandom() & 32'h0000_0ffc;
	data = $urandom();
	addr = base + offs;
	clear_inputs();
	i_class = exec_isa_pkg::LDSTR;
	i_alu_opc = exec_isa_pkg::ADD;
	i_ra = base;
	i_op2_rb = 1'b0;
	i_imm32 = offs;
	i_rb = data;
	i_mem_store = 1'b1;
	i_mem_width = 2'b10;
	i_valid = 1'b1;
	next_edge();
	check_val("store mar", addr, o_mar);
	check_val("store mdr", data, o_mdr);
	check_val("store strobes and width", 5'b01110,
		{o_mem_load, o_mem_store, o_mem_wr_en, o_mem_width});
	check_val("store wr_val", offs, o_wr_val);
	clear_inputs();
	i_alu_opc = exec_isa_pkg::ADD;
	i_ra = data;
	i_rb = base;
	i_update_rd = 1'b1;
	next_edge();
	check_val("mar held", addr, o_mar);
	check_val("strobes after store", 0, {o_mem_store, o_mem_wr_en});
	check_val("add after store", data + base, o_alu_out);
	clear_inputs();
	i_class = exec_isa_pkg::BRANCH;
	i_branch_cond = exec_isa_pkg::B;
	i_is_call = 1'b1;
	i_pc_plus_4 = addr + 4;
	i_update_rd = 1'b1;
	i_rd_sel = 4'hf;
	next_edge();
	check_val("call link value", addr + 4, o_wr_val);
	check_val("call taken", 1, o_branch_taken);
	check_val("call rd", 4'hf, o_rd_sel);
	clear_inputs();
	i_data_abort = 1'b1;
	next_edge();
	read_cr(exec_state_pkg::DATA_FAULT, val);
	check_val("data fault address", addr, val);
	finish_test();
endtask

/* verif/exec_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_stage_tb;

	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int ALU_PAIRS = 20;
	localparam int ALU_OP_COUNT = 13;
	localparam int CMP_PAIRS = 4;
	localparam int CONDITIONS = 11;
	// Margin on top of about 30 cycles for the four short tests
	localparam int MAX_CYCLES = RESET_CYCLES + ALU_PAIRS * ALU_OP_COUNT +
		CMP_PAIRS * (CONDITIONS + 1) + 76;

	logic clk;
	logic rst;

	// --------------------------------------------------
	// DUT ports
	// --------------------------------------------------
	exec_isa_pkg::word_t i_ra, i_rb, i_imm32, i_pc_plus_4;
	exec_isa_pkg::word_t i_irq_fault_address, i_dbg_cr_wr_val;
	exec_isa_pkg::reg_sel_t i_rd_sel;
	exec_isa_pkg::alu_opc_e i_alu_opc;
	exec_isa_pkg::mem_width_t i_mem_width;
	exec_isa_pkg::branch_cc_e i_branch_cond;
	exec_isa_pkg::instr_class_e i_class;
	exec_state_pkg::cr_sel_e i_cr_sel, i_dbg_cr_sel;
	logic i_update_rd, i_op1_ra, i_op1_rb, i_op2_rb, i_mem_load, i_mem_store, i_is_call;
	logic i_update_carry, i_update_flags, i_write_cr, i_is_swi, i_is_rfe, i_data_abort;
	logic i_exception_start, i_exception_disable_irqs, i_irq_start, i_valid, i_dbg_cr_wr_en;
	exec_isa_pkg::word_t o_alu_out, o_wr_val, o_mar, o_mdr, o_dbg_cr_val;
	exec_isa_pkg::reg_sel_t o_rd_sel;
	exec_isa_pkg::mem_width_t o_mem_width;
	exec_state_pkg::vector_base_t o_vector_base;
	logic o_wr_result, o_branch_taken, o_stall_clear, o_mem_load, o_mem_store, o_mem_wr_en;
	logic o_valid, o_irqs_enabled;

	int cycle_count;
	int test_errors;
	int total_errors;
	int tests_clean;
	int tests_dirty;
	string test_name;

	exec_stage dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
		$display("test failed");
		$finish;
	end

	// --------------------------------------------------
	// Stimulus and check helpers
	// --------------------------------------------------
	task automatic clear_inputs();
		{i_ra, i_rb, i_imm32, i_pc_plus_4, i_irq_fault_address, i_dbg_cr_wr_val} = '0;
		{i_update_rd, i_op1_rb, i_mem_load, i_mem_store, i_is_call, i_update_carry} = '0;
		{i_update_flags, i_write_cr, i_is_swi, i_is_rfe, i_data_abort, i_exception_start} = '0;
		{i_exception_disable_irqs, i_irq_start, i_valid, i_dbg_cr_wr_en} = '0;
		i_op1_ra = 1'b1; // Operands come from ra and rb unless a test says otherwise
		i_op2_rb = 1'b1;
		i_rd_sel = '0;
		i_mem_width = '0;
		i_alu_opc = exec_isa_pkg::COPYA;
		i_branch_cond = exec_isa_pkg::NE;
		i_class = exec_isa_pkg::ARITH;
		i_cr_sel = exec_state_pkg::VECTOR;
		i_dbg_cr_sel = exec_state_pkg::VECTOR;
	endtask

	task automatic next_edge();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic read_cr(input exec_state_pkg::cr_sel_e sel, output exec_isa_pkg::word_t val);
		i_dbg_cr_sel = sel;
		#1;
		val = o_dbg_cr_val;
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("%s finished with %0d errors", test_name, test_errors);
		if (test_errors == 0)
			tests_clean++;
		else
			tests_dirty++;
		total_errors += test_errors;
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic exec_isa_pkg::alu_opc_e alu_op_at(input int k);
		case (k)
		0: return exec_isa_pkg::ADD;
		1: return exec_isa_pkg::SUB;
		2: return exec_isa_pkg::AND;
		3: return exec_isa_pkg::OR;
		4: return exec_isa_pkg::XOR;
		5: return exec_isa_pkg::LSL;
		6: return exec_isa_pkg::LSR;
		7: return exec_isa_pkg::ASR;
		8: return exec_isa_pkg::BIC;
		9: return exec_isa_pkg::BST;
		10: return exec_isa_pkg::MOVHI;
		11: return exec_isa_pkg::COPYA;
		default: return exec_isa_pkg::COPYB;
		endcase
	endfunction

	function automatic exec_isa_pkg::word_t alu_ref(input exec_isa_pkg::alu_opc_e opc,
		input exec_isa_pkg::word_t a, input exec_isa_pkg::word_t b);
		exec_isa_pkg::word_t r;
		int sh;
		sh = b[4:0];
		r = a;
		case (opc)
		exec_isa_pkg::ADD:   r = a + b;
		exec_isa_pkg::SUB:   r = a - b;
		exec_isa_pkg::AND:   r = a & b;
		exec_isa_pkg::OR:    r = a | b;
		exec_isa_pkg::XOR:   r = a ^ b;
		exec_isa_pkg::LSL:   r = a << sh;
		exec_isa_pkg::LSR:   r = a >> sh;
		exec_isa_pkg::ASR: begin
			for (int i = 0; i < 32; i++)
				r[i] = (i + sh < 32) ? a[i + sh] : a[31]; // Sign fills the top
		end
		exec_isa_pkg::BIC:   r[sh] = 1'b0;
		exec_isa_pkg::BST:   r[sh] = 1'b1;
		exec_isa_pkg::MOVHI: r = a | (b & 32'h0000_ffff);
		exec_isa_pkg::COPYA: r = a;
		exec_isa_pkg::COPYB: r = b;
		default:             r = '0;
		endcase
		return r;
	endfunction

	// Expected outcome of a branch after comparing a with b
	function automatic logic cond_ref(input exec_isa_pkg::branch_cc_e cc,
		input exec_isa_pkg::word_t a, input exec_isa_pkg::word_t b);
		case (cc)
		exec_isa_pkg::NE:   return a != b;
		exec_isa_pkg::EQ:   return a == b;
		exec_isa_pkg::GT:   return a > b;
		exec_isa_pkg::LT:   return a < b;
		exec_isa_pkg::GTS:  return $signed(a) > $signed(b);
		exec_isa_pkg::LTS:  return $signed(a) < $signed(b);
		exec_isa_pkg::B:    return 1'b1;
		exec_isa_pkg::GTE:  return a >= b;
		exec_isa_pkg::GTES: return $signed(a) >= $signed(b);
		exec_isa_pkg::LTE:  return a <= b;
		exec_isa_pkg::LTES: return $signed(a) <= $signed(b);
		default:            return 1'b0;
		endcase
	endfunction

	`include "exec_stage_tests.svh"

	initial begin
		void'($urandom(32'h75f));
		total_errors = 0;
		tests_clean = 0;
		tests_dirty = 0;
		test_errors = 0;
		rst = 1'b1;
		clear_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		reset_values();
		alu_random_ops();
		carry_chain();
		compare_and_branch();
		control_reg_access();
		exception_entry_exit();
		memory_and_call();
		$display("Summary: %0d tests clean, %0d tests with errors, %0d errors in total",
			tests_clean, tests_dirty, total_errors);
		if (total_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
